//--- bp_pkg.sv
// branch predictor shared definitions
package bp_pkg;

    // RISC-V major opcodes seen at resolve time
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_OTHER  = 7'b0010011
    } op_e;

    // what a BTB entry was trained by
    typedef enum logic {
        KIND_BRANCH = 1'b0,
        KIND_JUMP   = 1'b1
    } btb_kind_e;

    // default table sizes, all powers of two
    localparam int DEF_BTB_ENTRIES = 32;
    localparam int DEF_GHR_BITS    = 5;
    localparam int DEF_QUEUE_DEPTH = 4;

    // counter value after reset, weakly not taken
    localparam logic [1:0] PHT_INIT = 2'b01;

endpackage

//--- btb.sv
// branch target buffer
`timescale 1ns/10ps

module btb #(
    parameter int NUM_BTB_ENTRIES = bp_pkg::DEF_BTB_ENTRIES
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic [31:0]       rd_pc_i,
    output logic              hit_o,
    output bp_pkg::btb_kind_e kind_o,
    output logic [31:0]       target_o,
    input  logic              we_i,
    input  logic [31:0]       wr_pc_i,
    input  logic [31:0]       wr_target_i,
    input  bp_pkg::btb_kind_e wr_kind_i
);
    import bp_pkg::*;

    localparam int IDX_BITS = $clog2(NUM_BTB_ENTRIES);

    logic [31:0]                tag_mem    [NUM_BTB_ENTRIES];
    logic [31:0]                target_mem [NUM_BTB_ENTRIES];
    btb_kind_e                  kind_mem   [NUM_BTB_ENTRIES];
    logic [NUM_BTB_ENTRIES-1:0] valid_q;

    logic [IDX_BITS-1:0] rd_idx;
    logic [IDX_BITS-1:0] wr_idx;

    // index starts above the byte offset
    assign rd_idx = rd_pc_i[IDX_BITS+1:2];
    assign wr_idx = wr_pc_i[IDX_BITS+1:2];

    // full PC kept as tag so aliasing never gives a false hit
    assign hit_o    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_pc_i);
    assign kind_o   = kind_mem[rd_idx];
    assign target_o = target_mem[rd_idx];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[wr_idx]    <= wr_pc_i;
            target_mem[wr_idx] <= wr_target_i;
            kind_mem[wr_idx]   <= wr_kind_i;
        end
    end

endmodule

//--- gshare_pht.sv
// gshare pattern history table
`timescale 1ns/10ps

module gshare_pht #(
    parameter int NUM_GHR_BITS = bp_pkg::DEF_GHR_BITS
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [31:0]             rd_pc_i,
    output logic [NUM_GHR_BITS-1:0] rd_index_o,
    output logic                    taken_o,
    input  logic                    we_i,
    input  logic [NUM_GHR_BITS-1:0] wr_index_i,
    input  logic                    increment_i,
    input  logic                    shift_i
);
    import bp_pkg::*;

    localparam int PHT_SIZE = 1 << NUM_GHR_BITS;

    logic [1:0]              pht_q [PHT_SIZE];
    logic [NUM_GHR_BITS-1:0] ghr_q;
    logic [1:0]              wr_count;

    // word address bits folded with global history
    assign rd_index_o = rd_pc_i[NUM_GHR_BITS+1:2] ^ ghr_q;
    assign taken_o    = pht_q[rd_index_o][1];
    assign wr_count   = pht_q[wr_index_i];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_SIZE; i++) begin
                pht_q[i] <= PHT_INIT;
            end
        end else if (we_i) begin
            // saturate at 0 and 3
            if (increment_i && (wr_count != 2'b11)) begin
                pht_q[wr_index_i] <= wr_count + 2'd1;
            end else if (!increment_i && (wr_count != 2'b00)) begin
                pht_q[wr_index_i] <= wr_count - 2'd1;
            end
        end
    end

    // history only records taken branches
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr_q <= '0;
        end else if (shift_i) begin
            ghr_q <= {ghr_q[NUM_GHR_BITS-2:0], 1'b1};
        end
    end

endmodule

//--- fetch_pc_gen.sv
// fetch program counter
`timescale 1ns/10ps

module fetch_pc_gen (
    input  logic              clk,
    input  logic              reset_i,
    input  logic [31:0]       boot_pc_i,
    input  logic              full_i,
    input  logic              redirect_i,
    input  logic [31:0]       redirect_pc_i,
    input  logic              btb_hit_i,
    input  bp_pkg::btb_kind_e btb_kind_i,
    input  logic [31:0]       btb_target_i,
    input  logic              pht_taken_i,
    output logic [31:0]       pc_o,
    output logic              fetch_valid_o,
    output logic              pred_taken_o,
    output logic [31:0]       pred_target_o
);
    import bp_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] pc_plus4;
    logic        run_q;

    assign pc_o     = pc_q;
    assign pc_plus4 = pc_q + 32'd4;

    // jumps always taken, branches follow the counter msb
    assign pred_taken_o  = btb_hit_i && ((btb_kind_i == KIND_JUMP) || pht_taken_i);
    assign pred_target_o = pred_taken_o ? btb_target_i : pc_plus4;

    // no fetch while the queue is full or a redirect is in flight
    assign fetch_valid_o = run_q && !full_i && !redirect_i;

    // fetch starts in the cycle after reset releases
    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= boot_pc_i;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (fetch_valid_o) begin
            pc_q <= pred_target_o;
        end
    end

endmodule

//--- predict_queue.sv
// in-flight prediction FIFO
`timescale 1ns/10ps

module predict_queue #(
    parameter int QUEUE_DEPTH  = bp_pkg::DEF_QUEUE_DEPTH,
    parameter int NUM_GHR_BITS = bp_pkg::DEF_GHR_BITS
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    push_i,
    input  logic [31:0]             push_pc_i,
    input  logic                    push_taken_i,
    input  logic [31:0]             push_target_i,
    input  logic [NUM_GHR_BITS-1:0] push_index_i,
    input  logic                    pop_i,
    input  logic                    flush_i,
    output logic                    full_o,
    output logic                    nonempty_o,
    output logic [31:0]             head_pc_o,
    output logic                    head_taken_o,
    output logic [31:0]             head_target_o,
    output logic [NUM_GHR_BITS-1:0] head_index_o
);
    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

    logic [31:0]             pc_mem     [QUEUE_DEPTH];
    logic                    taken_mem  [QUEUE_DEPTH];
    logic [31:0]             target_mem [QUEUE_DEPTH];
    logic [NUM_GHR_BITS-1:0] index_mem  [QUEUE_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [PTR_BITS:0]   count_q;
    logic                do_push;
    logic                do_pop;

    assign full_o     = (count_q == (PTR_BITS+1)'(QUEUE_DEPTH));
    assign nonempty_o = (count_q != '0);
    assign do_push    = push_i && !full_o;
    assign do_pop     = pop_i && nonempty_o;

    assign head_pc_o     = pc_mem[rd_ptr_q];
    assign head_taken_o  = taken_mem[rd_ptr_q];
    assign head_target_o = target_mem[rd_ptr_q];
    assign head_index_o  = index_mem[rd_ptr_q];

    // pointers wrap naturally with a power of two depth
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (PTR_BITS+1)'(do_push) - (PTR_BITS+1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr_q]     <= push_pc_i;
            taken_mem[wr_ptr_q]  <= push_taken_i;
            target_mem[wr_ptr_q] <= push_target_i;
            index_mem[wr_ptr_q]  <= push_index_i;
        end
    end

endmodule

//--- branch_resolve.sv
// branch resolution and training
`timescale 1ns/10ps

module branch_resolve #(
    parameter int NUM_GHR_BITS = bp_pkg::DEF_GHR_BITS
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    ex_valid_i,
    input  bp_pkg::op_e             ex_op_i,
    input  logic                    ex_taken_i,
    input  logic [31:0]             ex_target_i,
    input  logic [31:0]             head_pc_i,
    input  logic                    head_taken_i,
    input  logic [31:0]             head_target_i,
    input  logic [NUM_GHR_BITS-1:0] head_index_i,
    output logic                    pop_o,
    output logic                    redirect_o,
    output logic [31:0]             redirect_pc_o,
    output logic                    btb_we_o,
    output logic [31:0]             btb_pc_o,
    output logic [31:0]             btb_target_o,
    output bp_pkg::btb_kind_e       btb_kind_o,
    output logic                    pht_we_o,
    output logic                    pht_increment_o,
    output logic [NUM_GHR_BITS-1:0] pht_index_o,
    output logic                    ghr_shift_o
);
    import bp_pkg::*;

    logic        is_branch;
    logic        is_jump;
    logic        resolve;
    logic        actual_taken;
    logic        mispredict;
    logic        redirect_q;
    logic [31:0] redirect_pc_q;

    assign is_branch = (ex_op_i == OP_BRANCH);
    assign is_jump   = (ex_op_i == OP_JAL) || (ex_op_i == OP_JALR);

    // an outcome arriving in the redirect cycle is wrong-path and ignored
    assign resolve      = ex_valid_i && !redirect_q;
    assign actual_taken = is_jump || (is_branch && ex_taken_i);
    assign mispredict   = resolve && ((actual_taken != head_taken_i) ||
                          (actual_taken && (ex_target_i != head_target_i)));

    assign pop_o         = resolve;
    assign redirect_o    = redirect_q;
    assign redirect_pc_o = redirect_pc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= mispredict;
        end
    end

    // not taken falls through to the next word
    always_ff @(posedge clk) begin
        if (mispredict) begin
            redirect_pc_q <= actual_taken ? ex_target_i : head_pc_i + 32'd4;
        end
    end

    // jumps and taken branches allocate
    assign btb_we_o     = resolve && actual_taken;
    assign btb_pc_o     = head_pc_i;
    assign btb_target_o = ex_target_i;
    assign btb_kind_o   = is_jump ? KIND_JUMP : KIND_BRANCH;

    // counter trained at the index used for the prediction
    assign pht_we_o        = resolve && is_branch;
    assign pht_increment_o = ex_taken_i;
    assign pht_index_o     = head_index_i;
    assign ghr_shift_o     = resolve && is_branch && ex_taken_i;

endmodule

//--- branch_predictor_top.sv
// branch prediction subsystem
`timescale 1ns/10ps

module branch_predictor_top #(
    parameter int NUM_BTB_ENTRIES = bp_pkg::DEF_BTB_ENTRIES,
    parameter int NUM_GHR_BITS    = bp_pkg::DEF_GHR_BITS,
    parameter int QUEUE_DEPTH     = bp_pkg::DEF_QUEUE_DEPTH
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [31:0] boot_pc_i,
    input  logic        ex_valid_i,
    input  bp_pkg::op_e ex_op_i,
    input  logic        ex_taken_i,
    input  logic [31:0] ex_target_i,
    output logic [31:0] fetch_pc_o,
    output logic        fetch_valid_o,
    output logic        pred_taken_o,
    output logic [31:0] pred_target_o,
    output logic        redirect_o,
    output logic [31:0] redirect_pc_o
);
    import bp_pkg::*;

    logic                    btb_hit;
    btb_kind_e               btb_kind;
    logic [31:0]             btb_target;
    logic                    pht_taken;
    logic [NUM_GHR_BITS-1:0] pht_rd_index;

    logic                    full;
    logic                    nonempty;
    logic [31:0]             head_pc;
    logic                    head_taken;
    logic [31:0]             head_target;
    logic [NUM_GHR_BITS-1:0] head_index;
    logic                    pop;

    logic                    btb_we;
    logic [31:0]             btb_wr_pc;
    logic [31:0]             btb_wr_target;
    btb_kind_e               btb_wr_kind;
    logic                    pht_we;
    logic                    pht_increment;
    logic [NUM_GHR_BITS-1:0] pht_wr_index;
    logic                    ghr_shift;

    fetch_pc_gen u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .boot_pc_i     (boot_pc_i),
        .full_i        (full),
        .redirect_i    (redirect_o),
        .redirect_pc_i (redirect_pc_o),
        .btb_hit_i     (btb_hit),
        .btb_kind_i    (btb_kind),
        .btb_target_i  (btb_target),
        .pht_taken_i   (pht_taken),
        .pc_o          (fetch_pc_o),
        .fetch_valid_o (fetch_valid_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o)
    );

    btb #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES)
    ) u_btb (
        .clk         (clk),
        .reset_i     (reset_i),
        .rd_pc_i     (fetch_pc_o),
        .hit_o       (btb_hit),
        .kind_o      (btb_kind),
        .target_o    (btb_target),
        .we_i        (btb_we),
        .wr_pc_i     (btb_wr_pc),
        .wr_target_i (btb_wr_target),
        .wr_kind_i   (btb_wr_kind)
    );

    gshare_pht #(
        .NUM_GHR_BITS (NUM_GHR_BITS)
    ) u_pht (
        .clk         (clk),
        .reset_i     (reset_i),
        .rd_pc_i     (fetch_pc_o),
        .rd_index_o  (pht_rd_index),
        .taken_o     (pht_taken),
        .we_i        (pht_we),
        .wr_index_i  (pht_wr_index),
        .increment_i (pht_increment),
        .shift_i     (ghr_shift)
    );

    predict_queue #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .NUM_GHR_BITS (NUM_GHR_BITS)
    ) u_queue (
        .clk           (clk),
        .reset_i       (reset_i),
        .push_i        (fetch_valid_o),
        .push_pc_i     (fetch_pc_o),
        .push_taken_i  (pred_taken_o),
        .push_target_i (pred_target_o),
        .push_index_i  (pht_rd_index),
        .pop_i         (pop),
        .flush_i       (redirect_o),
        .full_o        (full),
        .nonempty_o    (nonempty),
        .head_pc_o     (head_pc),
        .head_taken_o  (head_taken),
        .head_target_o (head_target),
        .head_index_o  (head_index)
    );

    // outcomes only arrive while something is queued
    branch_resolve #(
        .NUM_GHR_BITS (NUM_GHR_BITS)
    ) u_resolve (
        .clk             (clk),
        .reset_i         (reset_i),
        .ex_valid_i      (ex_valid_i && nonempty),
        .ex_op_i         (ex_op_i),
        .ex_taken_i      (ex_taken_i),
        .ex_target_i     (ex_target_i),
        .head_pc_i       (head_pc),
        .head_taken_i    (head_taken),
        .head_target_i   (head_target),
        .head_index_i    (head_index),
        .pop_o           (pop),
        .redirect_o      (redirect_o),
        .redirect_pc_o   (redirect_pc_o),
        .btb_we_o        (btb_we),
        .btb_pc_o        (btb_wr_pc),
        .btb_target_o    (btb_wr_target),
        .btb_kind_o      (btb_wr_kind),
        .pht_we_o        (pht_we),
        .pht_increment_o (pht_increment),
        .pht_index_o     (pht_wr_index),
        .ghr_shift_o     (ghr_shift)
    );

endmodule

//--- branch_predictor_chk.sv
// branch predictor assertions
`timescale 1ns/10ps

module branch_predictor_chk (
    input logic clk,
    input logic reset_i,
    input logic redirect_i,
    input logic fetch_valid_i,
    input logic full_i
);

    // outputs come up quiet after reset
    reset_quiet: assert property (@(posedge clk)
        reset_i |=> (!redirect_i && !fetch_valid_i))
        else $error("redirect or fetch active right after reset");

    // a redirect lasts one cycle only
    redirect_single: assert property (@(posedge clk) disable iff (reset_i)
        redirect_i |=> !redirect_i)
        else $error("redirect held for two cycles");

    redirect_no_fetch: assert property (@(posedge clk) disable iff (reset_i)
        redirect_i |-> !fetch_valid_i)
        else $error("fetch valid during redirect");

    // push into a full queue would drop an entry
    no_push_full: assert property (@(posedge clk) disable iff (reset_i)
        full_i |-> !fetch_valid_i)
        else $error("push while queue full");

endmodule

bind branch_predictor_top branch_predictor_chk u_chk (
    .clk           (clk),
    .reset_i       (reset_i),
    .redirect_i    (redirect_o),
    .fetch_valid_i (fetch_valid_o),
    .full_i        (full)
);

//--- tb_branch_predictor.sv
// branch predictor testbench
`timescale 1ns/10ps

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int BTB_N      = DEF_BTB_ENTRIES;
    localparam int GHR_N      = DEF_GHR_BITS;
    localparam int DEPTH      = DEF_QUEUE_DEPTH;
    localparam int BTB_IDX    = $clog2(BTB_N);
    localparam int RESET_CYC  = 16;
    localparam int N_RANDOM   = 400;
    localparam int MAX_CYCLES = (N_RANDOM + 40) * 8 + 4 * (RESET_CYC + 10);
    localparam logic [31:0] BOOT = 32'h0000_1000;
    localparam logic [31:0] FAR  = 32'h0000_1040;

    logic        clk = 1'b0;
    logic        reset_i;
    logic [31:0] boot_pc_i;
    logic        ex_valid_i;
    op_e         ex_op_i;
    logic        ex_taken_i;
    logic [31:0] ex_target_i;
    logic [31:0] fetch_pc_o;
    logic        fetch_valid_o;
    logic        pred_taken_o;
    logic [31:0] pred_target_o;
    logic        redirect_o;
    logic [31:0] redirect_pc_o;

    // reference model state
    logic              m_ready = 1'b0;
    logic              m_live = 1'b0;
    logic [31:0]       m_pc;
    logic              m_run;
    logic              m_bvalid [BTB_N];
    logic [31:0]       m_btag   [BTB_N];
    logic [31:0]       m_btgt   [BTB_N];
    btb_kind_e         m_bkind  [BTB_N];
    logic [1:0]        m_pht    [1 << GHR_N];
    logic [GHR_N-1:0]  m_ghr;
    logic [31:0]       m_qpc    [DEPTH];
    logic              m_qtk    [DEPTH];
    logic [31:0]       m_qtgt   [DEPTH];
    logic [GHR_N-1:0]  m_qidx   [DEPTH];
    int                m_count;
    int                m_rd;
    int                m_wr;
    logic              m_redirect;
    logic [31:0]       m_redirect_pc;

    // expected combinational outputs
    logic              e_taken;
    logic [31:0]       e_target;
    logic              e_valid;
    logic [GHR_N-1:0]  e_idx;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_err_base = 0;
    int          cycles = 0;
    logic [15:0] lfsr = 16'd75;

    branch_predictor_top #(
        .NUM_BTB_ENTRIES (BTB_N),
        .NUM_GHR_BITS    (GHR_N),
        .QUEUE_DEPTH     (DEPTH)
    ) DUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .boot_pc_i     (boot_pc_i),
        .ex_valid_i    (ex_valid_i),
        .ex_op_i       (ex_op_i),
        .ex_taken_i    (ex_taken_i),
        .ex_target_i   (ex_target_i),
        .fetch_pc_o    (fetch_pc_o),
        .fetch_valid_o (fetch_valid_o),
        .pred_taken_o  (pred_taken_o),
        .pred_target_o (pred_target_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    always #2 clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            val = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function void model_predict();
        int  bi;
        logic hit;
        bi = int'(m_pc[BTB_IDX+1:2]);
        e_idx = m_pc[GHR_N+1:2] ^ m_ghr;
        hit = m_bvalid[bi] && (m_btag[bi] == m_pc);
        e_taken = hit && ((m_bkind[bi] == KIND_JUMP) || m_pht[e_idx][1]);
        e_target = e_taken ? m_btgt[bi] : m_pc + 32'd4;
        e_valid = m_run && (m_count != DEPTH) && !m_redirect;
    endfunction

    function void model_reset(input logic [31:0] boot);
        m_pc = boot;
        m_run = 1'b0;
        for (int i = 0; i < BTB_N; i++) begin
            m_bvalid[i] = 1'b0;
        end
        for (int i = 0; i < (1 << GHR_N); i++) begin
            m_pht[i] = PHT_INIT;
        end
        m_ghr = '0;
        m_count = 0;
        m_rd = 0;
        m_wr = 0;
        m_redirect = 1'b0;
    endfunction

    // one clock edge of the reference model
    function void model_step(input logic ev, input op_e op, input logic tk,
                             input logic [31:0] tg);
        logic resolve;
        logic act;
        logic mis;
        logic is_br;
        logic is_jmp;
        int   bi;
        model_predict();
        is_br = (op == OP_BRANCH);
        is_jmp = (op == OP_JAL) || (op == OP_JALR);
        resolve = ev && (m_count != 0) && !m_redirect;
        act = is_jmp || (is_br && tk);
        mis = resolve && ((act != m_qtk[m_rd]) || (act && (tg != m_qtgt[m_rd])));
        if (resolve && act) begin
            bi = int'(m_qpc[m_rd][BTB_IDX+1:2]);
            m_bvalid[bi] = 1'b1;
            m_btag[bi] = m_qpc[m_rd];
            m_btgt[bi] = tg;
            m_bkind[bi] = is_jmp ? KIND_JUMP : KIND_BRANCH;
        end
        if (resolve && is_br) begin
            if (tk && m_pht[m_qidx[m_rd]] != 2'd3) begin
                m_pht[m_qidx[m_rd]] += 2'd1;
            end
            if (!tk && m_pht[m_qidx[m_rd]] != 2'd0) begin
                m_pht[m_qidx[m_rd]] -= 2'd1;
            end
            if (tk) begin
                m_ghr = {m_ghr[GHR_N-2:0], 1'b1};
            end
        end
        if (mis) begin
            m_redirect_pc = act ? tg : m_qpc[m_rd] + 32'd4;
        end
        if (m_redirect) begin
            m_pc = m_redirect_pc;
            m_count = 0;
            m_rd = 0;
            m_wr = 0;
        end else begin
            if (e_valid) begin
                m_qpc[m_wr] = m_pc;
                m_qtk[m_wr] = e_taken;
                m_qtgt[m_wr] = e_target;
                m_qidx[m_wr] = e_idx;
                m_wr = (m_wr + 1) % DEPTH;
                m_count++;
                m_pc = e_target;
            end
            if (resolve) begin
                m_rd = (m_rd + 1) % DEPTH;
                m_count--;
            end
        end
        m_redirect = mis;
        m_run = 1'b1;
    endfunction

    always @(posedge clk) begin
        m_live <= !reset_i;
        if (reset_i) begin
            model_reset(boot_pc_i);
            m_ready <= 1'b1;
        end else if (m_ready) begin
            model_step(ex_valid_i, ex_op_i, ex_taken_i, ex_target_i);
        end
    end

    task automatic check(input string what, input logic [31:0] got,
                         input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // compare against the model every cycle
    always @(negedge clk) begin
        if (m_live && m_ready) begin
            model_predict();
            check("fetch_pc_o", fetch_pc_o, m_pc);
            check("fetch_valid_o", 32'(fetch_valid_o), 32'(e_valid));
            check("pred_taken_o", 32'(pred_taken_o), 32'(e_taken));
            check("pred_target_o", pred_target_o, e_target);
            check("redirect_o", 32'(redirect_o), 32'(m_redirect));
            if (m_redirect) begin
                check("redirect_pc_o", redirect_pc_o, m_redirect_pc);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic do_reset();
        reset_i = 1'b1;
        repeat (RESET_CYC) @(negedge clk);
        reset_i = 1'b0;
    endtask

    // one execute pulse once something is queued
    task automatic resolve(input op_e op, input logic tk, input logic [31:0] tg);
        while (m_count == 0 || m_redirect) @(negedge clk);
        ex_valid_i = 1'b1;
        ex_op_i = op;
        ex_taken_i = tk;
        ex_target_i = tg;
        @(negedge clk);
        ex_valid_i = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - test_err_base);
        test_err_base = errors;
    endtask

    initial begin
        op_e op;
        reset_i = 1'b1;
        boot_pc_i = BOOT;
        ex_valid_i = 1'b0;
        ex_op_i = OP_OTHER;
        ex_taken_i = 1'b0;
        ex_target_i = '0;
        @(negedge clk);
        do_reset();

        repeat (DEPTH + 3) @(negedge clk);
        check("fetch_valid_o when full", 32'(fetch_valid_o), 32'd0);
        check("fetch_pc_o when full", fetch_pc_o, BOOT + 32'(4 * DEPTH));
        end_test("sequential fetch");

        do_reset();
        resolve(OP_JAL, 1'b1, FAR);
        check("jump redirect_o", 32'(redirect_o), 32'd1);
        check("jump redirect_pc_o", redirect_pc_o, FAR);
        // jump back so the first jump is fetched again
        resolve(OP_JAL, 1'b1, BOOT);
        check("return redirect_o", 32'(redirect_o), 32'd1);
        check("return redirect_pc_o", redirect_pc_o, BOOT);
        @(negedge clk);
        check("jump fetch_pc_o", fetch_pc_o, BOOT);
        check("jump pred_taken_o", 32'(pred_taken_o), 32'd1);
        check("jump pred_target_o", pred_target_o, FAR);
        end_test("jump training");

        do_reset();
        repeat (8) resolve(OP_BRANCH, 1'b1, BOOT);
        repeat (2) @(negedge clk);
        check("loop fetch_pc_o", fetch_pc_o, BOOT);
        check("loop pred_taken_o", 32'(pred_taken_o), 32'd1);
        end_test("counter saturation");

        resolve(OP_BRANCH, 1'b0, BOOT);
        check("not taken redirect_o", 32'(redirect_o), 32'd1);
        check("not taken redirect_pc_o", redirect_pc_o, BOOT + 32'd4);
        end_test("not taken redirect");

        do_reset();
        for (int n = 0; n < N_RANDOM; n++) begin
            if (rand_bits(1) == 1) @(negedge clk);
            case (rand_bits(2))
                0: op = OP_BRANCH;
                1: op = OP_JAL;
                2: op = OP_JALR;
                default: op = OP_OTHER;
            endcase
            resolve(op, rand_bits(1) == 1, BOOT + (rand_bits(3) << 2));
        end
        repeat (4) @(negedge clk);
        end_test("random mix");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
bp_pkg.sv
btb.sv
gshare_pht.sv
fetch_pc_gen.sv
predict_queue.sv
branch_resolve.sv
branch_predictor_top.sv
branch_predictor_chk.sv
tb_branch_predictor.sv

//--- Makefile
# Verilator build for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from grep, so a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
